//--- src/dcache_config.svh
// widths are fixed by the burst protocol; changing them needs matching aligner logic
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------

`define DCACHE_ADDR_W        32   // cpu and burst byte address
`define DCACHE_WRITE_DATA_W  32   // store data from the cpu, one dword
`define DCACHE_READ_DATA_W   64   // load data back to the cpu, up to 8 bytes
`define DCACHE_READ_BURST_W  96   // three dwords from memory
`define DCACHE_WRITE_BURST_W 56   // seven bytes, 4 data bytes shifted by up to 3

// ----------------------------------------
// access limits
// ----------------------------------------

`define DCACHE_READ_MAX_LEN  8    // bytes per load
`define DCACHE_WRITE_MAX_LEN 4    // bytes per store

`endif

//--- src/dcache_pkg.sv
// shared length and state types; lengths are plain counts and zero means no access
`default_nettype none

package dcache_pkg;

   // ----------------------------------------
   // access lengths
   // ----------------------------------------

   // load byte count, legal 1..8
   typedef logic [3:0] read_len_t;

   // store byte count, legal 1..4
   typedef logic [2:0] write_len_t;

   // burst length in dwords
   // reads use 1..3, writes 1..2
   typedef logic [1:0] dword_len_t;

   // ----------------------------------------
   // controller state
   // ----------------------------------------

   // one transaction in flight at most
   typedef enum logic [1:0] {
      ST_IDLE          = 2'd0,  // waiting for a cpu request
      ST_READ_BURST    = 2'd1,  // read burst issued, waiting for data
      ST_WRITE_THROUGH = 2'd2   // store posted, write burst in flight
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/dcache_read_align.sv
// combinational only; expects length 1..8 while a load is pending, zero length means unused
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_read_align (
   input  wire  [`DCACHE_ADDR_W-1:0]       address,      // byte address of the load
   input  dcache_pkg::read_len_t           length,       // bytes wanted
   input  wire  [`DCACHE_READ_BURST_W-1:0] burst_data,   // dwords from memory
   output dcache_pkg::dword_len_t          dword_length, // dwords the range touches
   output logic [3:0]                      byte_length,  // plain byte count for memory
   output logic [`DCACHE_READ_DATA_W-1:0]  read_data     // aligned load result
);

   // ----------------------------------------
   // burst size
   // ----------------------------------------

   logic [1:0] offset;     // byte within the first dword
   logic [3:0] last_byte;  // offset of last byte, relative to dword base

   assign offset = address[1:0];

   // last byte index 0..10, its dword index is bits 3:2
   assign last_byte = {2'b00, offset} + length - 4'd1;

   assign dword_length = last_byte[3:2] + 2'd1;  // 1..3
   assign byte_length  = length;                 // passed straight through

   // ----------------------------------------
   // data extraction
   // ----------------------------------------

   logic [`DCACHE_READ_BURST_W-1:0] shifted;  // first wanted byte at bit 0
   logic [`DCACHE_READ_DATA_W-1:0]  keep;     // byte mask, ones below length

   // drop the leading bytes of the first dword
   assign shifted = burst_data >> {offset, 3'b000};

   always_comb begin
      keep = '0;
      for (int i = 0; i < `DCACHE_READ_MAX_LEN; i++) begin
         if (i < int'(length)) begin
            keep[i*8 +: 8] = 8'hff;  // byte belongs to the load
         end
      end
   end

   // bytes above length read back as zero
   assign read_data = shifted[`DCACHE_READ_DATA_W-1:0] & keep;

   // ----------------------------------------
   // checks
   // ----------------------------------------

   // zero length is the idle value, anything above 8 is a cpu bug
   always_comb begin
      assert (length <= 4'(`DCACHE_READ_MAX_LEN))
         else $error("dcache_read_align: load length %0d out of range", length);
   end

endmodule

`default_nettype wire

//--- src/dcache_write_align.sv
// combinational only; length 1..4, bytes above length in write_data are sent but not enabled
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_write_align (
   input  wire  [`DCACHE_ADDR_W-1:0]        address,       // byte address of the store
   input  dcache_pkg::write_len_t           length,        // bytes to write
   input  wire  [`DCACHE_WRITE_DATA_W-1:0]  write_data,    // store data, lsb first
   output dcache_pkg::dword_len_t           dword_length,  // 1 or 2
   output logic [3:0]                       byteenable_0,  // first dword
   output logic [3:0]                       byteenable_1,  // second dword
   output logic [`DCACHE_WRITE_BURST_W-1:0] burst_data     // data placed at its byte lanes
);

   // ----------------------------------------
   // byte enables
   // ----------------------------------------

   logic [1:0] offset;     // byte lane of the first byte
   logic [7:0] len_mask;   // length ones from bit 0
   logic [7:0] byte_mask;  // enables over both dwords

   assign offset = address[1:0];

   always_comb begin
      len_mask = '0;
      for (int i = 0; i < `DCACHE_WRITE_MAX_LEN; i++) begin
         len_mask[i] = (i < int'(length));  // one per stored byte
      end
   end

   // move the mask up to the first lane
   assign byte_mask = len_mask << offset;

   assign byteenable_0 = byte_mask[3:0];
   assign byteenable_1 = byte_mask[7:4];

   // second dword only when the store spills over the boundary
   assign dword_length = (|byteenable_1) ? 2'd2 : 2'd1;

   // ----------------------------------------
   // data placement
   // ----------------------------------------

   logic [`DCACHE_WRITE_BURST_W-1:0] data_wide;  // store data zero extended

   assign data_wide = {{(`DCACHE_WRITE_BURST_W - `DCACHE_WRITE_DATA_W){1'b0}}, write_data};

   // shift by whole bytes, lane n of burst carries byte n of the two dwords
   assign burst_data = data_wide << {offset, 3'b000};

endmodule

`default_nettype wire

//--- src/dcache_uncached_ctrl.sv
// one transaction at a time; do inputs and their qualifiers must stay held until done
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_uncached_ctrl (
   input  wire                      clk,
   input  wire                      rst_n,

   // cpu load
   input  wire                      read_do,
   output logic                     read_done,

   // cpu store
   input  wire                      write_do,
   output logic                     write_done,
   input  wire [`DCACHE_ADDR_W-1:0] write_address,

   // memory bursts
   output logic                     readburst_do,
   input  wire                      readburst_done,
   output logic                     writeburst_do,
   input  wire                      writeburst_done,

   // icache snoop notice
   output logic                     icache_snoop_do,
   output logic [`DCACHE_ADDR_W-1:0] icache_snoop_address,

   // cache maintenance, nothing cached so acked at once
   input  wire                      invd_do,
   output logic                     invd_done,
   input  wire                      wbinvd_do,
   output logic                     wbinvd_done,

   output logic                     busy
);

   // ----------------------------------------
   // state
   // ----------------------------------------

   dcache_pkg::ctrl_state_t state;

   logic idle;         // ready for a new request
   logic write_start;  // store accepted this cycle
   logic read_start;   // load accepted this cycle

   assign idle        = (state == dcache_pkg::ST_IDLE);
   assign write_start = idle && write_do;               // stores win
   assign read_start  = idle && !write_do && read_do;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= dcache_pkg::ST_IDLE;
      end else begin
         case (state)
            dcache_pkg::ST_IDLE: begin
               if (write_start) begin
                  state <= dcache_pkg::ST_WRITE_THROUGH;
               end else if (read_start) begin
                  state <= dcache_pkg::ST_READ_BURST;
               end
            end
            dcache_pkg::ST_READ_BURST: begin
               if (readburst_done) state <= dcache_pkg::ST_IDLE;  // data arrives with done
            end
            dcache_pkg::ST_WRITE_THROUGH: begin
               if (writeburst_done) state <= dcache_pkg::ST_IDLE;
            end
            default: state <= dcache_pkg::ST_IDLE;  // unused encoding
         endcase
      end
   end

   // ----------------------------------------
   // outputs
   // ----------------------------------------

   // store is posted, cpu released in the accept cycle
   assign write_done    = write_start;
   assign writeburst_do = write_start;  // one cycle, state leaves idle next

   // icache sees every store as it is accepted
   assign icache_snoop_do      = write_start;
   assign icache_snoop_address = write_address;

   assign readburst_do = read_start;  // one cycle pulse
   assign read_done    = (state == dcache_pkg::ST_READ_BURST) && readburst_done;

   // maintenance only when no load or store starts this cycle
   assign invd_done   = idle && !write_do && !read_do && invd_do;
   assign wbinvd_done = idle && !write_do && !read_do && wbinvd_do;

   assign busy = !idle;

   // ----------------------------------------
   // checks
   // ----------------------------------------

   // no second launch right behind a burst
   a_one_burst: assert property (
      @(posedge clk) disable iff (!rst_n)
      (readburst_do || writeburst_do) |=> !(readburst_do || writeburst_do)
   ) else $error("dcache_uncached_ctrl: burst launched while another is in flight");

   // memory must not answer a read that was never issued
   a_rdone_in_burst: assert property (
      @(posedge clk) disable iff (!rst_n)
      readburst_done |-> (state == dcache_pkg::ST_READ_BURST)
   ) else $error("dcache_uncached_ctrl: readburst_done outside read burst");

endmodule

`default_nettype wire

//--- src/dcache_uncached.sv
// uncached only: no tag or data rams, burst addresses are the held cpu addresses
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_uncached (
   input  wire                              clk,
   input  wire                              rst_n,

   // ----------------------------------------
   // cpu side
   // ----------------------------------------
   input  wire                              dcacheread_do,
   output logic                             dcacheread_done,
   input  dcache_pkg::read_len_t            dcacheread_length,
   input  wire  [`DCACHE_ADDR_W-1:0]        dcacheread_address,
   output logic [`DCACHE_READ_DATA_W-1:0]   dcacheread_data,

   input  wire                              dcachewrite_do,
   output logic                             dcachewrite_done,
   input  dcache_pkg::write_len_t           dcachewrite_length,
   input  wire  [`DCACHE_ADDR_W-1:0]        dcachewrite_address,
   input  wire  [`DCACHE_WRITE_DATA_W-1:0]  dcachewrite_data,

   // ----------------------------------------
   // memory side
   // ----------------------------------------
   output logic                             readburst_do,
   input  wire                              readburst_done,
   output logic [`DCACHE_ADDR_W-1:0]        readburst_address,
   output dcache_pkg::dword_len_t           readburst_dword_length,
   output logic [3:0]                       readburst_byte_length,
   input  wire  [`DCACHE_READ_BURST_W-1:0]  readburst_data,

   output logic                             writeburst_do,
   input  wire                              writeburst_done,
   output logic [`DCACHE_ADDR_W-1:0]        writeburst_address,
   output dcache_pkg::dword_len_t           writeburst_dword_length,
   output logic [3:0]                       writeburst_byteenable_0,
   output logic [3:0]                       writeburst_byteenable_1,
   output logic [`DCACHE_WRITE_BURST_W-1:0] writeburst_data,

   // icache snoop and maintenance
   output logic                             dcachetoicache_write_do,
   output logic [`DCACHE_ADDR_W-1:0]        dcachetoicache_write_address,
   input  wire                              invddata_do,
   output logic                             invddata_done,
   input  wire                              wbinvddata_do,
   output logic                             wbinvddata_done,

   output logic                             dcache_busy
);

   assign readburst_address  = dcacheread_address;   // held by cpu until done
   assign writeburst_address = dcachewrite_address;

   dcache_read_align u_read_align (
      .address      (dcacheread_address),
      .length       (dcacheread_length),
      .burst_data   (readburst_data),
      .dword_length (readburst_dword_length),
      .byte_length  (readburst_byte_length),
      .read_data    (dcacheread_data)          // valid with dcacheread_done
   );

   dcache_write_align u_write_align (
      .address      (dcachewrite_address),
      .length       (dcachewrite_length),
      .write_data   (dcachewrite_data),
      .dword_length (writeburst_dword_length),
      .byteenable_0 (writeburst_byteenable_0),
      .byteenable_1 (writeburst_byteenable_1),
      .burst_data   (writeburst_data)
   );

   dcache_uncached_ctrl u_ctrl (
      .clk                  (clk),
      .rst_n                (rst_n),
      .read_do              (dcacheread_do),
      .read_done            (dcacheread_done),
      .write_do             (dcachewrite_do),
      .write_done           (dcachewrite_done),
      .write_address        (dcachewrite_address),
      .readburst_do         (readburst_do),
      .readburst_done       (readburst_done),
      .writeburst_do        (writeburst_do),
      .writeburst_done      (writeburst_done),
      .icache_snoop_do      (dcachetoicache_write_do),
      .icache_snoop_address (dcachetoicache_write_address),
      .invd_do              (invddata_do),
      .invd_done            (invddata_done),
      .wbinvd_do            (wbinvddata_do),
      .wbinvd_done          (wbinvddata_done),
      .busy                 (dcache_busy)
   );

endmodule

`default_nettype wire

//--- testbench/tb_dcache_mem.sv
// 256-byte memory, address bits above 7 ignored; one read and one write burst pending at most
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module tb_dcache_mem (
   input  wire                              clk,
   input  wire                              rst_n,
   input  wire                              readburst_do,
   output logic                             readburst_done,
   input  wire  [`DCACHE_ADDR_W-1:0]        readburst_address,
   output logic [`DCACHE_READ_BURST_W-1:0]  readburst_data,
   input  wire                              writeburst_do,
   output logic                             writeburst_done,
   input  wire  [`DCACHE_ADDR_W-1:0]        writeburst_address,
   input  wire  [3:0]                       writeburst_byteenable_0,
   input  wire  [3:0]                       writeburst_byteenable_1,
   input  wire  [`DCACHE_WRITE_BURST_W-1:0] writeburst_data
);

   logic [7:0] mem [0:255];

   logic [7:0]                       rd_base;    // dword aligned start of the read
   int                               rd_wait;    // cycles to done, 0 when idle
   logic [7:0]                       wr_base;
   logic [7:0]                       wr_enable;  // both dwords, lane 0 first
   logic [`DCACHE_WRITE_BURST_W-1:0] wr_data;
   int                               wr_wait;

   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 256; i++) begin
            mem[8'(i)] <= 8'(i * 37 + 11);  // same fill as the reference model
         end
         readburst_done  <= 1'b0;
         writeburst_done <= 1'b0;
         readburst_data  <= '0;
         rd_wait         <= 0;
         wr_wait         <= 0;
      end else begin
         readburst_done  <= 1'b0;  // one cycle pulses
         writeburst_done <= 1'b0;

         // ----------------------------------------
         // read burst, three dwords always
         if (readburst_do) begin
            rd_base <= {readburst_address[7:2], 2'b00};
            rd_wait <= 1 + int'($urandom_range(4, 0));  // 1..5 cycles
         end else if (rd_wait == 1) begin
            for (int k = 0; k < 12; k++) begin
               readburst_data[k*8 +: 8] <= mem[8'(rd_base + 8'(k))];  // wraps at 256
            end
            readburst_done <= 1'b1;
            rd_wait        <= 0;
         end else if (rd_wait > 1) begin
            rd_wait <= rd_wait - 1;
         end

         // ----------------------------------------
         // write burst, captured at do since the cpu is released
         if (writeburst_do) begin
            wr_base   <= {writeburst_address[7:2], 2'b00};
            wr_enable <= {writeburst_byteenable_1, writeburst_byteenable_0};
            wr_data   <= writeburst_data;
            wr_wait   <= 1 + int'($urandom_range(4, 0));
         end else if (wr_wait == 1) begin
            for (int k = 0; k < 7; k++) begin
               if (wr_enable[k]) begin
                  mem[8'(wr_base + 8'(k))] <= wr_data[k*8 +: 8];
               end
            end
            writeburst_done <= 1'b1;
            wr_wait         <= 0;
         end else if (wr_wait > 1) begin
            wr_wait <= wr_wait - 1;
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_dcache.sv
// random traffic against a 256-byte model; addresses wrap at 256 like the memory model
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module tb_dcache;

   localparam int N_LOADS     = 60;
   localparam int N_STORES    = 60;  // each followed by a load of the same bytes
   localparam int N_PAIRS     = 20;  // store and load raised together
   localparam int N_MAINT     = 20;  // store then invd or wbinvd
   localparam int N_TRANS     = N_LOADS + 2 * N_STORES + 2 * N_PAIRS + 2 * N_MAINT;
   localparam int MAX_DELAY   = 5;
   localparam int CYCLE_LIMIT = 20 * N_TRANS * MAX_DELAY;

   logic clk = 1'b0;
   logic rst_n;

   logic                             dcacheread_do, dcacheread_done;
   dcache_pkg::read_len_t            dcacheread_length;
   logic [`DCACHE_ADDR_W-1:0]        dcacheread_address;
   logic [`DCACHE_READ_DATA_W-1:0]   dcacheread_data;
   logic                             dcachewrite_do, dcachewrite_done;
   dcache_pkg::write_len_t           dcachewrite_length;
   logic [`DCACHE_ADDR_W-1:0]        dcachewrite_address;
   logic [`DCACHE_WRITE_DATA_W-1:0]  dcachewrite_data;
   logic                             readburst_do, readburst_done;
   logic [`DCACHE_ADDR_W-1:0]        readburst_address;
   dcache_pkg::dword_len_t           readburst_dword_length;
   logic [3:0]                       readburst_byte_length;
   logic [`DCACHE_READ_BURST_W-1:0]  readburst_data;
   logic                             writeburst_do, writeburst_done;
   logic [`DCACHE_ADDR_W-1:0]        writeburst_address;
   dcache_pkg::dword_len_t           writeburst_dword_length;
   logic [3:0]                       writeburst_byteenable_0, writeburst_byteenable_1;
   logic [`DCACHE_WRITE_BURST_W-1:0] writeburst_data;
   logic                             dcachetoicache_write_do;
   logic [`DCACHE_ADDR_W-1:0]        dcachetoicache_write_address;
   logic                             invddata_do, invddata_done;
   logic                             wbinvddata_do, wbinvddata_done;
   logic                             dcache_busy;

   logic [7:0]              model [0:255];  // reference bytes
   int                      errors = 0;
   int                      cycles = 0;
   logic                    in_flight;      // a burst is outstanding
   dcache_pkg::ctrl_state_t ctrl_state;

   assign ctrl_state = UUT.u_ctrl.state;

   always #2 clk = ~clk;  // 4 ns period

   dcache_uncached UUT (.*);

   tb_dcache_mem u_mem (.*);

   // ----------------------------------------
   // model helpers
   // ----------------------------------------

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("ERROR t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
      end
   endtask

   function automatic logic [63:0] expected_load(input logic [31:0] addr, input int len);
      logic [63:0] value;
      value = '0;  // bytes above len stay zero
      for (int i = 0; i < len; i++) begin
         value[i*8 +: 8] = model[8'(addr[7:0] + 8'(i))];
      end
      return value;
   endfunction

   function automatic int dwords_touched(input logic [31:0] addr, input int len);
      return (int'(addr[1:0]) + len - 1) / 4 + 1;
   endfunction

   function automatic logic [7:0] store_mask(input logic [31:0] addr, input int len);
      logic [7:0] mask;
      mask = '0;
      for (int i = 0; i < len; i++) begin
         mask[int'(addr[1:0]) + i] = 1'b1;  // one lane per stored byte
      end
      return mask;
   endfunction

   // called at the negedge where dcachewrite_done is high
   task automatic check_store_accept(input logic [31:0] addr, input int len,
                                     input logic [31:0] data);
      logic [7:0] mask;
      mask = store_mask(addr, len);
      check_value("writeburst_do", 64'(1), 64'(writeburst_do));
      check_value("writeburst_address", 64'(addr), 64'(writeburst_address));
      check_value("dcachetoicache_write_do", 64'(1), 64'(dcachetoicache_write_do));
      check_value("dcachetoicache_write_address", 64'(addr),
                  64'(dcachetoicache_write_address));
      check_value("writeburst_byteenable_0", 64'(mask[3:0]), 64'(writeburst_byteenable_0));
      check_value("writeburst_byteenable_1", 64'(mask[7:4]), 64'(writeburst_byteenable_1));
      check_value("writeburst_dword_length", 64'(dwords_touched(addr, len)),
                  64'(writeburst_dword_length));
      for (int i = 0; i < len; i++) begin
         model[8'(addr[7:0] + 8'(i))] = data[i*8 +: 8];
      end
   endtask

   // ----------------------------------------
   // transactions
   // ----------------------------------------

   task automatic finish_load(input logic [31:0] addr, input int len);
      @(negedge clk);
      while (!dcacheread_done) @(negedge clk);
      check_value("dcacheread_data", expected_load(addr, len), dcacheread_data);
      check_value("readburst_address", 64'(addr), 64'(readburst_address));
      check_value("readburst_dword_length", 64'(dwords_touched(addr, len)),
                  64'(readburst_dword_length));
      check_value("readburst_byte_length", 64'(len), 64'(readburst_byte_length));
      @(posedge clk);
      dcacheread_do <= 1'b0;
   endtask

   task automatic load_bytes(input logic [31:0] addr, input int len);
      @(posedge clk);
      dcacheread_do      <= 1'b1;
      dcacheread_address <= addr;
      dcacheread_length  <= dcache_pkg::read_len_t'(len);
      finish_load(addr, len);
   endtask

   task automatic store_bytes(input logic [31:0] addr, input int len, input logic [31:0] data);
      @(posedge clk);
      dcachewrite_do      <= 1'b1;
      dcachewrite_address <= addr;
      dcachewrite_length  <= dcache_pkg::write_len_t'(len);
      dcachewrite_data    <= data;
      @(negedge clk);
      while (!dcachewrite_done) @(negedge clk);  // may wait out a posted store
      check_store_accept(addr, len, data);
      @(posedge clk);
      dcachewrite_do <= 1'b0;
   endtask

   // store and load raised in one idle cycle, load reads the dword of the store
   task automatic store_then_load(input logic [31:0] addr, input int len,
                                  input logic [31:0] data);
      @(negedge clk);
      while (dcache_busy) @(negedge clk);
      @(posedge clk);
      dcachewrite_do      <= 1'b1;
      dcachewrite_address <= addr;
      dcachewrite_length  <= dcache_pkg::write_len_t'(len);
      dcachewrite_data    <= data;
      dcacheread_do       <= 1'b1;
      dcacheread_address  <= {addr[31:2], 2'b00};
      dcacheread_length   <= dcache_pkg::read_len_t'(8);
      @(negedge clk);
      check_value("dcachewrite_done", 64'(1), 64'(dcachewrite_done));
      check_value("readburst_do", 64'(0), 64'(readburst_do));  // store wins
      check_store_accept(addr, len, data);
      @(posedge clk);
      dcachewrite_do <= 1'b0;
      finish_load({addr[31:2], 2'b00}, 8);
   endtask

   // raised while the posted store is still in flight
   task automatic run_maintenance(input bit wbinvd);
      @(posedge clk);
      invddata_do   <= !wbinvd;
      wbinvddata_do <= wbinvd;
      @(negedge clk);
      while (!(invddata_done || wbinvddata_done)) @(negedge clk);
      check_value("invddata_done", 64'(!wbinvd), 64'(invddata_done));
      check_value("wbinvddata_done", 64'(wbinvd), 64'(wbinvddata_done));
      check_value("dcache_busy", 64'(0), 64'(dcache_busy));
      @(posedge clk);
      invddata_do   <= 1'b0;
      wbinvddata_do <= 1'b0;
   endtask

   // ----------------------------------------
   // monitors and timeout
   // ----------------------------------------

   // expected busy, set by a request seen in idle and cleared by the burst done
   always @(posedge clk) begin
      if (!rst_n) begin
         in_flight <= 1'b0;
      end else if (!in_flight) begin
         in_flight <= dcachewrite_do || dcacheread_do;
      end else if (readburst_done || writeburst_done) begin
         in_flight <= 1'b0;
      end
   end

   always @(negedge clk) begin
      if (!rst_n) begin
         check_value("do/done outputs in reset", 64'(0),
                     64'({dcacheread_done, dcachewrite_done, readburst_do, writeburst_do,
                          dcachetoicache_write_do, invddata_done, wbinvddata_done,
                          dcache_busy}));
      end else begin
         check_value("dcachetoicache_write_do", 64'(dcachewrite_done),
                     64'(dcachetoicache_write_do));
         check_value("dcache_busy", 64'(in_flight), 64'(dcache_busy));
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run stopped after %0d cycles with the controller in state %s",
                  cycles, ctrl_state.name());
         $display("*** FAILED ***");
         $finish;
      end
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------

   initial begin
      logic [31:0] addr;
      logic [31:0] data;
      int          len;
      void'($urandom(32'hffc7_430a));
      for (int i = 0; i < 256; i++) begin
         model[8'(i)] = 8'(i * 37 + 11);  // matches memory fill
      end
      rst_n               <= 1'b0;
      dcacheread_do       <= 1'b0;
      dcacheread_length   <= '0;
      dcacheread_address  <= '0;
      dcachewrite_do      <= 1'b0;
      dcachewrite_length  <= '0;
      dcachewrite_address <= '0;
      dcachewrite_data    <= '0;
      invddata_do         <= 1'b0;
      wbinvddata_do       <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("do/done outputs after reset", 64'(0),
                  64'({dcacheread_done, dcachewrite_done, readburst_do, writeburst_do,
                       dcachetoicache_write_do, invddata_done, wbinvddata_done,
                       dcache_busy}));

      for (int n = 0; n < N_LOADS; n++) begin
         addr = $urandom();
         len  = 1 + int'($urandom_range(7, 0));
         load_bytes(addr, len);
      end
      for (int n = 0; n < N_STORES; n++) begin
         addr = $urandom();
         data = $urandom();
         len  = 1 + int'($urandom_range(3, 0));
         store_bytes(addr, len, data);
         load_bytes(addr, len);  // read back, crossing stores included
      end
      for (int n = 0; n < N_PAIRS; n++) begin
         addr = $urandom();
         data = $urandom();
         len  = 1 + int'($urandom_range(3, 0));
         store_then_load(addr, len, data);
      end
      for (int n = 0; n < N_MAINT; n++) begin
         addr = $urandom();
         data = $urandom();
         store_bytes(addr, 4, data);  // leaves the DUT busy
         run_maintenance(n[0]);
      end

      $display("tb_dcache finished with %0d errors", errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/dcache_pkg.sv
src/dcache_read_align.sv
src/dcache_write_align.sv
src/dcache_uncached_ctrl.sv
src/dcache_uncached.sv
testbench/tb_dcache_mem.sv
testbench/tb_dcache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it, exit status follows the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f vlog.f

output=$(./obj_dir/Vtb_dcache 2>&1 || true)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
   exit 0
fi
exit 1
